// File: logic/translator_config.svh
// slave translator configuration: bus widths, wait-state cycle counts and read latency
`ifndef TRANSLATOR_CONFIG_SVH
`define TRANSLATOR_CONFIG_SVH

// -------------------------------------------------------------------------
// bus widths
// -------------------------------------------------------------------------
`define TR_UAV_ADDR_W         32   // master side, byte addressed
`define TR_AV_ADDR_W          30   // peripheral side, word addressed
`define TR_WORD_SHIFT         2    // byte offset bits within one word
`define TR_DATA_W             32
`define TR_BYTEEN_W           4    // one enable per data byte

// -------------------------------------------------------------------------
// generated wait states
// -------------------------------------------------------------------------
// setup cycles before any strobe
`define TR_SETUP_CYCLES       1
// read strobe cycles after setup, before accept
`define TR_READ_WAIT_CYCLES   2
// extra write strobe cycles after the first
`define TR_WRITE_WAIT_CYCLES  1
// write low cycles before accept
`define TR_HOLD_CYCLES        1

// fixed peripheral read latency, must be one or more
`define TR_READ_LATENCY       2

// wide enough for the longest phase count
`define TR_WAIT_COUNT_W       3

`endif

// File: logic/avmm_types_pkg.sv
// memory-mapped bus vector types shared by the translator and its environment
`default_nettype none

package avmm_types_pkg;

`include "translator_config.svh"

   // -----------------------------------------------------------------------
   // addresses
   // -----------------------------------------------------------------------

   // master byte address
   typedef logic [`TR_UAV_ADDR_W-1:0] uav_addr_t;

   // peripheral word address, byte offset already removed
   typedef logic [`TR_AV_ADDR_W-1:0]  av_addr_t;

   // -----------------------------------------------------------------------
   // data and enables
   // -----------------------------------------------------------------------

   typedef logic [`TR_DATA_W-1:0]     data_t;      // read and write data
   typedef logic [`TR_BYTEEN_W-1:0]   byteen_t;    // one bit per byte lane

endpackage

`default_nettype wire

// File: logic/wait_state_pkg.sv
// wait-state sequencer types: FSM state encoding and per-state cycle counter
`default_nettype none

package wait_state_pkg;

`include "translator_config.svh"

   // phase of the current access
   typedef enum logic [1:0] {
      IDLE,       // no command under way
      SETUP,      // address out, strobes low
      ACCESS,     // read or write strobe high
      HOLD        // write strobe low, data still driven
   } seq_state_t;

   // cycles spent in the current phase
   typedef logic [`TR_WAIT_COUNT_W-1:0] wait_count_t;

endpackage

`default_nettype wire

// File: logic/wait_ctrl_if.sv
// request and wait-state control shared by sequencer, command mapper and latency tracker
`timescale 1ns/1ps
`default_nettype none

interface wait_ctrl_if;

   // master request, driven at the top level
   logic read;
   logic write;

   // generated by the sequencer
   logic waitrequest;    // high until the command completes
   logic read_accept;    // read completes in this cycle
   logic slave_read;     // read strobe gated to its window
   logic slave_write;    // write strobe gated to its window

   modport seq (
      input  read,
      input  write,
      output waitrequest,
      output read_accept,
      output slave_read,
      output slave_write
   );

   modport map (
      input  read,
      input  write,
      input  waitrequest
   );

   modport trk (
      input  read,
      input  write,
      input  read_accept
   );

endinterface

`default_nettype wire

// File: logic/wait_state_sequencer.sv
// wait-state sequencer: generates waitrequest and the windowed peripheral strobes
`timescale 1ns/1ps
`default_nettype none

`include "translator_config.svh"

module wait_state_sequencer
   import wait_state_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   wait_ctrl_if.seq  ctrl
);

   localparam bit          HAS_SETUP  = (`TR_SETUP_CYCLES > 0);
   localparam bit          HAS_HOLD   = (`TR_HOLD_CYCLES > 0);
   localparam wait_count_t SETUP_LAST = wait_count_t'(`TR_SETUP_CYCLES - 1);
   localparam wait_count_t READ_LAST  = wait_count_t'(`TR_READ_WAIT_CYCLES);
   localparam wait_count_t WRITE_LAST = wait_count_t'(`TR_WRITE_WAIT_CYCLES);
   localparam wait_count_t HOLD_LAST  = wait_count_t'(`TR_HOLD_CYCLES - 1);

   seq_state_t  state, cur_state, next_state;
   wait_count_t count, cur_count, next_count;
   logic        reset_override;
   logic        active;
   logic        last;

   // keeps waitrequest up in the first cycle out of reset
   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         reset_override <= 1'b1;
      else
         reset_override <= 1'b0;
   end

   // -------------------------------------------------------------------------
   // phase of the current cycle
   // -------------------------------------------------------------------------
   // a request seen in IDLE is the first cycle of its command
   always_comb begin
      if (state == IDLE) begin
         cur_state = HAS_SETUP ? SETUP : ACCESS;
         cur_count = '0;
      end else begin
         cur_state = state;
         cur_count = count;
      end
   end

   assign active = (ctrl.read | ctrl.write) & ~reset_override;

   // final cycle of the command
   always_comb begin
      if (ctrl.read)
         last = (cur_state == ACCESS) && (cur_count == READ_LAST);
      else if (HAS_HOLD)
         last = (cur_state == HOLD) && (cur_count == HOLD_LAST);
      else
         last = (cur_state == ACCESS) && (cur_count == WRITE_LAST);
   end

   assign ctrl.waitrequest = ~(active & last);
   assign ctrl.read_accept = active & ctrl.read & last;
   assign ctrl.slave_read  = active & ctrl.read & (cur_state == ACCESS);
   assign ctrl.slave_write = active & ctrl.write & (cur_state == ACCESS);

   // -------------------------------------------------------------------------
   // next phase
   // -------------------------------------------------------------------------
   always_comb begin
      next_state = cur_state;
      next_count = cur_count + 1'b1;
      if (!active || last) begin
         next_state = IDLE;          // back-to-back commands restart in setup
         next_count = '0;
      end else begin
         case (cur_state)
            SETUP: begin
               if (cur_count == SETUP_LAST) begin
                  next_state = ACCESS;
                  next_count = '0;
               end
            end
            ACCESS: begin
               if (ctrl.write && (cur_count == WRITE_LAST)) begin
                  next_state = HOLD;   // write strobe drops here
                  next_count = '0;
               end
            end
            default: begin
               next_state = cur_state;
            end
         endcase
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state <= IDLE;
         count <= '0;
      end else begin
         state <= next_state;
         count <= next_count;
      end
   end

endmodule

`default_nettype wire

// File: logic/read_latency_tracker.sv
// read latency tracker: fixed-latency readdatavalid plus chipselect and outputenable
`timescale 1ns/1ps
`default_nettype none

`include "translator_config.svh"

module read_latency_tracker
   import wait_state_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   wait_ctrl_if.trk  ctrl,
   output logic      readdatavalid,
   output logic      chipselect,
   output logic      outputenable
);

   localparam int LATENCY = `TR_READ_LATENCY;

   logic [LATENCY-1:0] stage;       // one bit per accepted read in flight
   wait_count_t        in_flight;
   logic               pending;

   // -------------------------------------------------------------------------
   // latency pipe
   // -------------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         stage <= '0;
      end else begin
         stage[0] <= ctrl.read_accept;
         for (int i = 1; i < LATENCY; i++) begin
            stage[i] <= stage[i-1];
         end
      end
   end

   assign readdatavalid = stage[LATENCY-1];   // data returns on this cycle

   // reads still waiting, the last stage is excluded
   always_comb begin
      in_flight = '0;
      for (int i = 0; i < LATENCY - 1; i++) begin
         in_flight = in_flight + wait_count_t'(stage[i]);
      end
   end

   assign pending = (in_flight != '0);

   // -------------------------------------------------------------------------
   // peripheral select
   // -------------------------------------------------------------------------
   // stay selected until every accepted read has its data underway
   assign chipselect   = ctrl.read | ctrl.write | pending;
   assign outputenable = ctrl.read | pending;   // reads only

endmodule

`default_nettype wire

// File: logic/command_mapper.sv
// command mapper: word address, data and byte enables, and the begintransfer pulse
`timescale 1ns/1ps
`default_nettype none

`include "translator_config.svh"

module command_mapper
   import avmm_types_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   wait_ctrl_if.map   ctrl,
   input  uav_addr_t  uav_address,
   input  data_t      uav_writedata,
   input  byteen_t    uav_byteenable,
   output av_addr_t   av_address,
   output data_t      av_writedata,
   output byteen_t    av_byteenable,
   output byteen_t    av_writebyteenable,
   output logic       begintransfer
);

   logic end_begin;   // first cycle of the command is over

   // drop the byte offset
   assign av_address    = uav_address[`TR_WORD_SHIFT +: `TR_AV_ADDR_W];
   assign av_writedata  = uav_writedata;
   assign av_byteenable = uav_byteenable;

   // byte lanes only enabled for writes
   assign av_writebyteenable = uav_byteenable & {`TR_BYTEEN_W{ctrl.write}};

   // -------------------------------------------------------------------------
   // begintransfer
   // -------------------------------------------------------------------------
   assign begintransfer = (ctrl.read | ctrl.write) & ~end_begin;

   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         end_begin <= 1'b0;
      else if (!ctrl.waitrequest)
         end_begin <= 1'b0;          // command completes, rearm
      else if (begintransfer)
         end_begin <= 1'b1;
   end

endmodule

`default_nettype wire

// File: logic/slave_translator.sv
// slave translator top: byte-addressed master port to a fixed-timing word peripheral
`timescale 1ns/1ps
`default_nettype none

module slave_translator
   import avmm_types_pkg::*;
(
   input  logic       clk,
   input  logic       reset,

   // -------------------------------------------------------------------------
   // master side
   // -------------------------------------------------------------------------
   input  uav_addr_t  uav_address,
   input  data_t      uav_writedata,
   input  byteen_t    uav_byteenable,
   input  logic       uav_read,
   input  logic       uav_write,
   output logic       uav_waitrequest,
   output data_t      uav_readdata,
   output logic       uav_readdatavalid,

   // -------------------------------------------------------------------------
   // peripheral side
   // -------------------------------------------------------------------------
   output av_addr_t   av_address,
   output data_t      av_writedata,
   output byteen_t    av_byteenable,
   output byteen_t    av_writebyteenable,
   output logic       av_read,
   output logic       av_write,
   output logic       av_begintransfer,
   output logic       av_chipselect,
   output logic       av_outputenable,
   input  data_t      av_readdata
);

   wait_ctrl_if ctrl ();

   // master request into the shared control bundle
   assign ctrl.read  = uav_read;
   assign ctrl.write = uav_write;

   assign uav_waitrequest = ctrl.waitrequest;
   assign av_read         = ctrl.slave_read;
   assign av_write        = ctrl.slave_write;
   assign uav_readdata    = av_readdata;   // same cycle, no register

   wait_state_sequencer i_seq (
      .clk   (clk),
      .reset (reset),
      .ctrl  (ctrl.seq)
   );

   command_mapper i_map (
      .clk                (clk),
      .reset              (reset),
      .ctrl               (ctrl.map),
      .uav_address        (uav_address),
      .uav_writedata      (uav_writedata),
      .uav_byteenable     (uav_byteenable),
      .av_address         (av_address),
      .av_writedata       (av_writedata),
      .av_byteenable      (av_byteenable),
      .av_writebyteenable (av_writebyteenable),
      .begintransfer      (av_begintransfer)
   );

   read_latency_tracker i_trk (
      .clk           (clk),
      .reset         (reset),
      .ctrl          (ctrl.trk),
      .readdatavalid (uav_readdatavalid),
      .chipselect    (av_chipselect),
      .outputenable  (av_outputenable)
   );

endmodule

`default_nettype wire

// File: testbench/tb_checks.svh
// testbench helpers: expected memory model, random source and value compare
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// contents of a word never written, built from the whole word address
function automatic data_t fill_word(input av_addr_t word);
   return {2'b00, word} ^ 32'hA5C3_0F69;
endfunction

// -------------------------------------------------------------------------
// expected memory, indexed by word
// -------------------------------------------------------------------------
// writes merge the enabled bytes, reads return the stored word
function automatic data_t ref_access(input bit is_write, input uav_addr_t addr,
                                     input data_t wdata, input byteen_t be);
   av_addr_t word;
   data_t    cur;
   word = av_addr_t'(addr >> `TR_WORD_SHIFT);   // byte offset ignored
   cur  = ref_mem.exists(word) ? ref_mem[word] : fill_word(word);
   if (is_write) begin
      for (int b = 0; b < `TR_BYTEEN_W; b++) begin
         if (be[b])
            cur[8*b +: 8] = wdata[8*b +: 8];
      end
      ref_mem[word] = cur;
   end
   return cur;
endfunction

// 32-bit linear congruential generator, upper bits are the useful ones
function automatic logic [31:0] lcg_next();
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   return lcg_state;
endfunction

task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                           input string what);
   if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
   end
endtask

`endif

// File: testbench/tb_slave_translator.sv
// testbench for the slave translator: random reads and writes against a peripheral model
`timescale 1ns/1ps
`default_nettype none

`include "translator_config.svh"

module tb_slave_translator
   import avmm_types_pkg::*;
();

   localparam int S       = `TR_SETUP_CYCLES;
   localparam int RW      = `TR_READ_WAIT_CYCLES;
   localparam int WW      = `TR_WRITE_WAIT_CYCLES;
   localparam int H       = `TR_HOLD_CYCLES;
   localparam int L       = `TR_READ_LATENCY;
   localparam int N_CMDS  = 40;
   localparam int TIMEOUT = N_CMDS * 12 + 100;

   logic      clk, reset;
   uav_addr_t uav_address;
   data_t     uav_writedata, uav_readdata, av_writedata, av_readdata;
   byteen_t   uav_byteenable, av_byteenable, av_writebyteenable;
   logic      uav_read, uav_write, uav_waitrequest, uav_readdatavalid;
   av_addr_t  av_address;
   logic      av_read, av_write, av_begintransfer, av_chipselect, av_outputenable;

   int          cycle = 0;
   int          value_errors = 0;
   int          other_errors = 0;
   logic [31:0] lcg_state;
   data_t       ref_mem[av_addr_t];   // expected contents
   data_t       per_mem[av_addr_t];   // peripheral model contents
   data_t       exp_q[$];             // expected read words in order
   int          acc_q[$];             // accept cycle of each read in flight
   int          rd_run = 0;
   data_t       rd_pipe[L];
   bit          busy = 1'b0;

`include "tb_checks.svh"

   slave_translator i_dut (.*);

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= TIMEOUT) begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT);
         $display("Test FAILED");
         $finish;
      end
   end

   // -------------------------------------------------------------------------
   // peripheral model, fixed timing
   // -------------------------------------------------------------------------
   always @(posedge clk) begin : peripheral_model
      data_t cur;
      if (av_write) begin
         cur = per_mem.exists(av_address) ? per_mem[av_address] : fill_word(av_address);
         for (int b = 0; b < `TR_BYTEEN_W; b++) begin
            if (av_writebyteenable[b])
               cur[8*b +: 8] = av_writedata[8*b +: 8];
         end
         per_mem[av_address] = cur;
      end
      rd_run = av_read ? rd_run + 1 : 0;
      for (int i = L - 1; i > 0; i--)
         rd_pipe[i] = rd_pipe[i-1];
      rd_pipe[0] = '0;
      if (rd_run == RW + 1) begin     // read accepted on this edge
         rd_pipe[0] = per_mem.exists(av_address) ? per_mem[av_address]
                                                 : fill_word(av_address);
         rd_run = 0;
      end
      av_readdata <= #1 rd_pipe[L-1];
   end

   // read data and latency against the expected queue
   always @(posedge clk) begin
      if (!reset && uav_readdatavalid) begin
         if (exp_q.size() == 0) begin
            other_errors++;
            $display("%0t: readdatavalid seen with no read outstanding", $time);
         end else begin
            check_value(uav_readdata, exp_q.pop_front(), "read data");
            check_value(cycle - acc_q.pop_front(), L, "read latency");
         end
      end
   end

   // per-cycle bus rules
   always @(posedge clk) begin : bus_monitor
      int   pending;
      logic exp_begin;
      if (!reset) begin
         pending = 0;
         foreach (acc_q[i]) begin
            if (acc_q[i] < cycle && cycle < acc_q[i] + L)
               pending++;
         end
         exp_begin = (uav_read | uav_write) & ~busy;   // first cycle of a command
         busy      = (uav_read | uav_write) & uav_waitrequest;
         check_value(av_address, uav_address >> `TR_WORD_SHIFT, "av_address");
         check_value(av_writedata, uav_writedata, "av_writedata");
         check_value(av_byteenable, uav_byteenable, "av_byteenable");
         check_value(av_writebyteenable, uav_write ? uav_byteenable : '0,
                     "av_writebyteenable");
         check_value(av_begintransfer, exp_begin, "av_begintransfer");
         check_value(av_chipselect, uav_read | uav_write | (pending != 0), "av_chipselect");
         check_value(av_outputenable, uav_read | (pending != 0), "av_outputenable");
         if (!uav_read)
            check_value(av_read, 0, "av_read outside a read");
         if (!uav_write)
            check_value(av_write, 0, "av_write outside a write");
      end
   end

   // holds one command until accepted, then checks its phase lengths
   task automatic run_command(input bit is_write, input uav_addr_t addr,
                              input data_t wdata, input byteen_t be);
      int n_wait, n_rd, n_wr, n_begin;
      bit waiting;
      n_wait  = 0;
      n_rd    = 0;
      n_wr    = 0;
      n_begin = 0;
      uav_address    = addr;
      uav_writedata  = wdata;
      uav_byteenable = be;
      uav_read       = !is_write;
      uav_write      = is_write;
      do begin
         @(posedge clk);
         waiting = uav_waitrequest;
         n_rd    += av_read;
         n_wr    += av_write;
         n_begin += av_begintransfer;
         n_wait  += waiting;
      end while (waiting);
      if (is_write) begin
         void'(ref_access(1'b1, addr, wdata, be));
      end else begin
         exp_q.push_back(ref_access(1'b0, addr, wdata, be));
         acc_q.push_back(cycle);
      end
      check_value(n_wait, is_write ? S + WW + H : S + RW, "waitrequest cycles");
      check_value(n_rd, is_write ? 0 : RW + 1, "av_read cycles");
      check_value(n_wr, is_write ? WW + 1 : 0, "av_write cycles");
      check_value(n_begin, 1, "begintransfer pulses");
      #1;
      uav_read  = 1'b0;
      uav_write = 1'b0;
   endtask

   // -------------------------------------------------------------------------
   // stimulus
   // -------------------------------------------------------------------------
   initial begin : stimulus
      logic [31:0] r;
      bit          is_write;
      int          gap;
      clk = 1'b0;
      reset = 1'b1;
      uav_address = '0;
      uav_writedata = '0;
      uav_byteenable = '0;
      uav_read = 1'b0;
      uav_write = 1'b0;
      av_readdata = '0;
      lcg_state = 32'd83903;
      repeat (5) @(posedge clk);
      #1 reset = 1'b0;
      @(posedge clk);
      check_value(uav_waitrequest, 1, "waitrequest after reset");
      #1;
      for (int n = 0; n < N_CMDS; n++) begin
         is_write = lcg_next() >> 31;
         r        = lcg_next();
         gap      = (lcg_next() >> 30) % 3;
         repeat (gap) begin
            @(posedge clk);
            #1;
         end
         // four regions of four words, any byte offset
         run_command(is_write, {r[31:30], 26'd0, r[29:26]}, lcg_next(),
                     byteen_t'(lcg_next() >> 28));
      end
      while (exp_q.size() != 0)
         @(posedge clk);
      repeat (2) @(posedge clk);
      $display("run complete: %0d value errors, %0d other errors", value_errors, other_errors);
      if (value_errors + other_errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: sources.f
+incdir+logic
+incdir+testbench
logic/avmm_types_pkg.sv
logic/wait_state_pkg.sv
logic/wait_ctrl_if.sv
logic/wait_state_sequencer.sv
logic/read_latency_tracker.sv
logic/command_mapper.sv
logic/slave_translator.sv
testbench/tb_slave_translator.sv

// File: Bender.yml
package:
  name: slave_translator

sources:
  - include_dirs:
      - logic
    files:
      - logic/avmm_types_pkg.sv
      - logic/wait_state_pkg.sv
      - logic/wait_ctrl_if.sv
      - logic/wait_state_sequencer.sv
      - logic/read_latency_tracker.sv
      - logic/command_mapper.sv
      - logic/slave_translator.sv
  - target: test
    include_dirs:
      - logic
      - testbench
    files:
      - testbench/tb_slave_translator.sv
